//--- sccb_pkg.sv
// Shared types, APB register map and boot table for the SCCB controller
`default_nettype none

package sccb_pkg;

    typedef enum logic {
        OP_WRITE, // Three-phase write
        OP_READ   // Two-phase write then two-phase read
    } sccb_op_e;

    typedef enum logic [2:0] {
        IDLE,
        START,
        SHIFT,
        ACK,
        STOP,
        RESTART_GAP
    } sccb_state_e;

    // APB byte offsets
    localparam logic [7:0] REG_ID     = 8'h00;
    localparam logic [7:0] REG_SUB    = 8'h04;
    localparam logic [7:0] REG_WDATA  = 8'h08;
    localparam logic [7:0] REG_RDATA  = 8'h0C;
    localparam logic [7:0] REG_STATUS = 8'h10;
    localparam logic [7:0] REG_CTRL   = 8'h14;

    localparam logic [7:0] CAM_ID = 8'h42; // Write address, bit 0 set for reads

    localparam int BOOT_LEN = 4;
    localparam logic [7:0] BOOT_SUB  [BOOT_LEN] = '{8'h12, 8'h11, 8'h0C, 8'h3E};
    localparam logic [7:0] BOOT_DATA [BOOT_LEN] = '{8'h80, 8'h01, 8'h04, 8'h19};

    // STATUS bit positions
    localparam int STAT_DONE   = 0;
    localparam int STAT_NACK   = 1;
    localparam int STAT_BUSY   = 2;
    localparam int STAT_BOOTED = 3;

endpackage

`default_nettype wire

//--- sccb_clk_gen.sv
// Quarter-bit tick generator that paces SIO_C while the bit engine runs
`timescale 1ns/1ps
`default_nettype none

module sccb_clk_gen #(
    parameter int CLK_DIV = 125 // PCLK cycles per quarter bit
) (
    input  wire  PCLK,
    input  wire  PRESETN,
    input  wire  run,
    output logic tick
);

    localparam int CW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic [CW-1:0] cnt;

    // Counter held at zero while idle so the first tick lands CLK_DIV cycles after run
    always_ff @(posedge PCLK or negedge PRESETN) begin
        if (!PRESETN) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (!run) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            tick <= (cnt == CW'(CLK_DIV - 1)); // One-cycle pulse on wrap
            if (cnt == CW'(CLK_DIV - 1))
                cnt <= '0;
            else
                cnt <= cnt + CW'(1);
        end
    end

endmodule

`default_nettype wire

//--- sccb_master.sv
// SCCB bit engine for write and write-then-read transactions with ACK sampling
`timescale 1ns/1ps
`default_nettype none

module sccb_master (
    input  wire                     PCLK,
    input  wire                     PRESETN,
    input  wire                     start,
    input  wire                     tick,
    input  wire sccb_pkg::sccb_op_e op,
    input  wire  [7:0]              id,
    input  wire  [7:0]              sub,
    input  wire  [7:0]              wdata,
    input  wire                     sio_d_in,
    output logic                    sio_d_oe,
    output logic                    sio_c,
    output logic                    busy,
    output logic                    done,
    output logic                    nack,
    output logic [7:0]              rdata
);
    import sccb_pkg::*;

    sccb_state_e state;
    sccb_op_e    op_r;
    logic [7:0]  id_r, sub_r, wdata_r;
    logic [7:0]  shreg;
    logic [1:0]  qtr;      // Quarter-bit phase
    logic [2:0]  bit_cnt;
    logic [1:0]  ph;       // Byte phase within a pass
    logic        second;   // Pass after the restart
    logic        sda;      // Level wanted on SIO_D
    logic        rd_phase; // Slave drives the data byte
    logic        last_ph;

    assign busy     = (state != IDLE);
    assign sio_d_oe = ~sda; // Open drain, only pulls low
    assign rd_phase = second && (ph == 2'd1);
    assign last_ph  = (op_r == OP_WRITE) ? (ph == 2'd2) : (ph == 2'd1);

    // Transaction fields captured at start
    always_ff @(posedge PCLK) begin
        if (start && state == IDLE) begin
            id_r    <= id;
            sub_r   <= sub;
            wdata_r <= wdata;
        end
    end

    always_ff @(posedge PCLK or negedge PRESETN) begin
        if (!PRESETN) begin
            state   <= IDLE;
            op_r    <= OP_WRITE;
            shreg   <= 8'hFF;
            qtr     <= 2'd0;
            bit_cnt <= 3'd0;
            ph      <= 2'd0;
            second  <= 1'b0;
            sda     <= 1'b1; // Line released
            sio_c   <= 1'b1;
            done    <= 1'b0;
            nack    <= 1'b0;
            rdata   <= 8'h00;
        end else begin
            done <= 1'b0;
            if (state == IDLE) begin
                if (start) begin
                    op_r   <= op;
                    qtr    <= 2'd0;
                    ph     <= 2'd0;
                    second <= 1'b0;
                    nack   <= 1'b0;
                    state  <= START;
                end
            end else if (tick) begin
                qtr <= qtr + 2'd1;
                case (state)
                    START: begin
                        if (qtr == 2'd0) sda <= 1'b1;
                        if (qtr == 2'd2) sda <= 1'b0; // SDA falls with SIO_C high
                        if (qtr == 2'd3) begin
                            sio_c   <= 1'b0;
                            shreg   <= second ? (id_r | 8'h01) : id_r; // Read ID on restart
                            bit_cnt <= 3'd0;
                            state   <= SHIFT;
                        end
                    end
                    SHIFT: begin
                        if (qtr == 2'd0) sda <= rd_phase ? 1'b1 : shreg[7]; // MSB first
                        if (qtr == 2'd1) sio_c <= 1'b1;
                        if (qtr == 2'd2) shreg <= {shreg[6:0], sio_d_in};
                        if (qtr == 2'd3) begin
                            sio_c   <= 1'b0;
                            bit_cnt <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7) state <= ACK;
                        end
                    end
                    ACK: begin
                        if (qtr == 2'd0) sda <= 1'b1;   // Slave ACK slot, or NA after read
                        if (qtr == 2'd1) sio_c <= 1'b1;
                        if (qtr == 2'd2 && !rd_phase) nack <= nack | sio_d_in;
                        if (qtr == 2'd3) begin
                            sio_c <= 1'b0;
                            if (rd_phase) rdata <= shreg;
                            if (last_ph) begin
                                state <= STOP;
                            end else begin
                                ph    <= ph + 2'd1;
                                // Contents ignored when the slave drives the byte
                                shreg <= (ph == 2'd0) ? sub_r : wdata_r;
                                state <= SHIFT;
                            end
                        end
                    end
                    STOP: begin
                        if (qtr == 2'd0) sda <= 1'b0;
                        if (qtr == 2'd1) sio_c <= 1'b1;
                        if (qtr == 2'd2) sda <= 1'b1; // SDA rises with SIO_C high
                        if (qtr == 2'd3) begin
                            if (op_r == OP_READ && !second) begin
                                second <= 1'b1;
                                ph     <= 2'd0;
                                state  <= RESTART_GAP;
                            end else begin
                                done  <= 1'b1;
                                state <= IDLE;
                            end
                        end
                    end
                    RESTART_GAP: begin
                        if (qtr == 2'd3) state <= START; // One idle bit time
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- sccb_arbiter.sv
// Fixed-priority arbiter granting the bit engine to the boot sequencer or APB block
`timescale 1ns/1ps
`default_nettype none

module sccb_arbiter (
    input  wire                     PCLK,
    input  wire                     PRESETN,
    input  wire                     boot_req,
    input  wire sccb_pkg::sccb_op_e boot_op,
    input  wire  [7:0]              boot_id,
    input  wire  [7:0]              boot_sub,
    input  wire  [7:0]              boot_wdata,
    input  wire                     apb_req,
    input  wire sccb_pkg::sccb_op_e apb_op,
    input  wire  [7:0]              apb_id,
    input  wire  [7:0]              apb_sub,
    input  wire  [7:0]              apb_wdata,
    input  wire                     busy,
    input  wire                     done,
    output logic                    boot_gnt,
    output logic                    apb_gnt,
    output logic                    boot_done,
    output logic                    apb_done,
    output logic                    start,
    output sccb_pkg::sccb_op_e      op,
    output logic [7:0]              id,
    output logic [7:0]              sub,
    output logic [7:0]              wdata
);

    logic issued; // Start already sent for current grant

    always_ff @(posedge PCLK or negedge PRESETN) begin
        if (!PRESETN) begin
            boot_gnt <= 1'b0;
            apb_gnt  <= 1'b0;
            issued   <= 1'b0;
            start    <= 1'b0;
        end else begin
            start <= 1'b0;
            if (!boot_gnt && !apb_gnt) begin
                if (!busy) begin
                    if (boot_req)     boot_gnt <= 1'b1; // Boot first
                    else if (apb_req) apb_gnt  <= 1'b1;
                end
            end else if (!issued) begin
                start  <= 1'b1; // Cycle after grant
                issued <= 1'b1;
            end else if (done) begin
                boot_gnt <= 1'b0;
                apb_gnt  <= 1'b0;
                issued   <= 1'b0;
            end
        end
    end

    // Done only reaches the owner
    assign boot_done = done & boot_gnt;
    assign apb_done  = done & apb_gnt;

    assign op    = apb_gnt ? apb_op    : boot_op;
    assign id    = apb_gnt ? apb_id    : boot_id;
    assign sub   = apb_gnt ? apb_sub   : boot_sub;
    assign wdata = apb_gnt ? apb_wdata : boot_wdata;

endmodule

`default_nettype wire

//--- sccb_boot_seq.sv
// Boot sequencer writing the fixed camera register table after reset
`timescale 1ns/1ps
`default_nettype none

module sccb_boot_seq (
    input  wire                PCLK,
    input  wire                PRESETN,
    input  wire                done,
    output logic               req,
    output sccb_pkg::sccb_op_e op,
    output logic [7:0]         id,
    output logic [7:0]         sub,
    output logic [7:0]         wdata,
    output logic               booted
);
    import sccb_pkg::*;

    localparam int IW = (BOOT_LEN > 1) ? $clog2(BOOT_LEN) : 1;

    logic [IW-1:0] idx; // Current table entry

    // Advance per completed write, NACK ignored so boot runs without a camera
    always_ff @(posedge PCLK or negedge PRESETN) begin
        if (!PRESETN) begin
            idx    <= '0;
            booted <= 1'b0;
        end else if (done && !booted) begin
            if (idx == IW'(BOOT_LEN - 1))
                booted <= 1'b1; // Idle until next reset
            else
                idx <= idx + IW'(1);
        end
    end

    assign req   = ~booted;
    assign op    = OP_WRITE;
    assign id    = CAM_ID;
    assign sub   = BOOT_SUB[idx];
    assign wdata = BOOT_DATA[idx];

endmodule

`default_nettype wire

//--- sccb_apb_regs.sv
// APB slave holding SCCB command fields, read data and sticky status
`timescale 1ns/1ps
`default_nettype none

module sccb_apb_regs (
    input  wire                PCLK,
    input  wire                PRESETN,
    input  wire                psel,
    input  wire                penable,
    input  wire                pwrite,
    input  wire  [7:0]         paddr,
    input  wire  [7:0]         pwdata,
    output logic [7:0]         prdata,
    output logic               pslverr,
    input  wire                done,
    input  wire                nack,
    input  wire  [7:0]         rdata,
    input  wire                booted,
    output logic               req,
    output sccb_pkg::sccb_op_e op,
    output logic [7:0]         id,
    output logic [7:0]         sub,
    output logic [7:0]         wdata
);
    import sccb_pkg::*;

    logic [7:0] rdata_r;
    logic [7:0] status;
    logic       stat_done, stat_nack;
    logic       wr_en, mapped, ro_hit;

    assign wr_en  = psel & penable & pwrite; // Zero-wait access phase
    assign mapped = paddr inside {REG_ID, REG_SUB, REG_WDATA, REG_RDATA, REG_STATUS, REG_CTRL};
    assign ro_hit = (paddr == REG_RDATA) || (paddr == REG_STATUS);
    assign pslverr = psel & penable & (~mapped | (pwrite & ro_hit));

    always_comb begin
        status              = 8'h00;
        status[STAT_DONE]   = stat_done;
        status[STAT_NACK]   = stat_nack;
        status[STAT_BUSY]   = req; // Busy until our own done
        status[STAT_BOOTED] = booted;
    end

    always_ff @(posedge PCLK or negedge PRESETN) begin
        if (!PRESETN) begin
            id        <= 8'h00;
            sub       <= 8'h00;
            wdata     <= 8'h00;
            rdata_r   <= 8'h00;
            req       <= 1'b0;
            op        <= OP_WRITE;
            stat_done <= 1'b0;
            stat_nack <= 1'b0;
        end else begin
            if (wr_en) begin
                case (paddr)
                    REG_ID:    id    <= pwdata;
                    REG_SUB:   sub   <= pwdata;
                    REG_WDATA: wdata <= pwdata;
                    REG_CTRL: begin
                        if (!req && (pwdata[1] || pwdata[0])) begin // Dropped while busy
                            req       <= 1'b1;
                            op        <= pwdata[1] ? OP_READ : OP_WRITE; // Read wins
                            stat_done <= 1'b0;
                            stat_nack <= 1'b0;
                        end
                    end
                    default: ;
                endcase
            end
            if (done) begin
                req       <= 1'b0;
                stat_done <= 1'b1; // Sticky until next command
                stat_nack <= nack;
                rdata_r   <= rdata;
            end
        end
    end

    always_comb begin
        case (paddr)
            REG_ID:     prdata = id;
            REG_SUB:    prdata = sub;
            REG_WDATA:  prdata = wdata;
            REG_RDATA:  prdata = rdata_r;
            REG_STATUS: prdata = status;
            REG_CTRL:   prdata = 8'h00; // Write-only strobe
            default:    prdata = 8'hFF;
        endcase
    end

endmodule

`default_nettype wire

//--- sccb_apb_top.sv
// Camera configuration controller with APB slave, boot sequencer and SCCB master
`timescale 1ns/1ps
`default_nettype none

module sccb_apb_top #(
    parameter int CLK_DIV = 125
) (
    input  wire        PCLK,
    input  wire        PRESETN,
    input  wire        psel,
    input  wire        penable,
    input  wire        pwrite,
    input  wire  [7:0] paddr,
    input  wire  [7:0] pwdata,
    output logic [7:0] prdata,
    output logic       pslverr,
    input  wire        sio_d_in,
    output logic       sio_d_oe,
    output logic       sio_c
);
    import sccb_pkg::*;

    logic       tick, busy, m_done, m_nack, start, booted;
    logic [7:0] m_rdata;
    sccb_op_e   op, boot_op, apb_op;
    logic [7:0] id, sub, wdata;
    logic       boot_req, boot_done, apb_req, apb_done;
    logic [7:0] boot_id, boot_sub, boot_wdata;
    logic [7:0] apb_id, apb_sub, apb_wdata;

    sccb_clk_gen #(.CLK_DIV(CLK_DIV)) u_clk_gen (
        .PCLK(PCLK), .PRESETN(PRESETN), .run(busy), .tick(tick)
    );

    sccb_master u_master (
        .PCLK(PCLK), .PRESETN(PRESETN), .start(start), .tick(tick),
        .op(op), .id(id), .sub(sub), .wdata(wdata),
        .sio_d_in(sio_d_in), .sio_d_oe(sio_d_oe), .sio_c(sio_c),
        .busy(busy), .done(m_done), .nack(m_nack), .rdata(m_rdata)
    );

    // Grants stay internal to the arbiter
    sccb_arbiter u_arbiter (
        .PCLK(PCLK), .PRESETN(PRESETN),
        .boot_req(boot_req), .boot_op(boot_op), .boot_id(boot_id),
        .boot_sub(boot_sub), .boot_wdata(boot_wdata),
        .apb_req(apb_req), .apb_op(apb_op), .apb_id(apb_id),
        .apb_sub(apb_sub), .apb_wdata(apb_wdata),
        .busy(busy), .done(m_done), .boot_gnt(), .apb_gnt(),
        .boot_done(boot_done), .apb_done(apb_done),
        .start(start), .op(op), .id(id), .sub(sub), .wdata(wdata)
    );

    sccb_boot_seq u_boot_seq (
        .PCLK(PCLK), .PRESETN(PRESETN), .done(boot_done),
        .req(boot_req), .op(boot_op), .id(boot_id), .sub(boot_sub),
        .wdata(boot_wdata), .booted(booted)
    );

    sccb_apb_regs u_apb_regs (
        .PCLK(PCLK), .PRESETN(PRESETN), .psel(psel), .penable(penable),
        .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
        .pslverr(pslverr), .done(apb_done), .nack(m_nack), .rdata(m_rdata),
        .booted(booted), .req(apb_req), .op(apb_op), .id(apb_id),
        .sub(apb_sub), .wdata(apb_wdata)
    );

endmodule

`default_nettype wire

//--- sccb_cam_model.sv
// Behavioral SCCB camera with a register file that answers only its own device ID
`timescale 1ns/1ps
`default_nettype none

module sccb_cam_model (
    input  wire  sio_c,
    input  wire  sio_d,
    output logic pull_low // Pulls the shared SIO_D line low
);
    import sccb_pkg::*;

    logic [7:0] regs [256];
    logic [7:0] sh, tx, sub_r;
    logic [3:0] cnt;       // SIO_C rises seen in this byte
    logic [1:0] nbyte;     // Byte within the current phase group
    logic       active, matched, reading;
    logic       c_q, d_q;  // Line levels before this event

    initial begin
        for (int i = 0; i < 256; i++)
            regs[i] = 8'(i) ^ 8'h5A; // Known reset contents
        pull_low = 1'b0;
        sh       = 8'h00;
        tx       = 8'h00;
        sub_r    = 8'h00;
        cnt      = 4'd0;
        nbyte    = 2'd0;
        active   = 1'b0;
        matched  = 1'b0;
        reading  = 1'b0;
        c_q      = 1'b1;
        d_q      = 1'b1;
    end

    always @(posedge sio_c or negedge sio_c or posedge sio_d or negedge sio_d) begin
        if (c_q === 1'b1 && sio_c === 1'b1 && d_q === 1'b1 && sio_d === 1'b0) begin
            active   = 1'b1; // Start, also the restart before a read
            cnt      = 4'd0;
            nbyte    = 2'd0;
            reading  = 1'b0;
            pull_low = 1'b0;
        end else if (c_q === 1'b1 && sio_c === 1'b1 && d_q === 1'b0 && sio_d === 1'b1) begin
            active   = 1'b0; // Stop
            pull_low = 1'b0;
        end else if (active && c_q === 1'b0 && sio_c === 1'b1) begin
            if (cnt < 4'd8) sh = {sh[6:0], sio_d}; // MSB first
            cnt = cnt + 4'd1;
        end else if (active && c_q === 1'b1 && sio_c === 1'b0) begin
            if (cnt == 4'd8) begin
                if (nbyte == 2'd0) begin
                    matched  = (sh[7:1] == CAM_ID[7:1]); // Write or read address
                    reading  = sh[0];
                    pull_low = matched;
                end else if (reading) begin
                    pull_low = 1'b0; // Master sends NA here
                end else begin
                    if (matched && nbyte == 2'd1) sub_r = sh;
                    if (matched && nbyte == 2'd2) regs[sub_r] = sh;
                    pull_low = matched;
                end
            end else if (cnt == 4'd9) begin
                cnt      = 4'd0; // ACK slot over
                nbyte    = nbyte + 2'd1;
                pull_low = 1'b0;
                if (reading && matched && nbyte == 2'd1) begin
                    tx       = regs[sub_r];
                    pull_low = ~tx[7];
                end
            end else if (reading && matched && nbyte == 2'd1 && cnt != 4'd0) begin
                tx       = tx << 1; // Next read bit while SIO_C low
                pull_low = ~tx[7];
            end
        end
        c_q = sio_c;
        d_q = sio_d;
    end

endmodule

`default_nettype wire

//--- tb_sccb_apb.sv
// Directed testbench for the APB camera configuration controller
`timescale 1ns/1ps
`default_nettype none

module tb_sccb_apb;
    import sccb_pkg::*;

    localparam int CLK_DIV = 4;
    localparam int WD_NS   = 12 * 200 * CLK_DIV * 20; // 12 transactions of 200 ticks

    logic       PCLK, PRESETN;
    logic       psel, penable, pwrite;
    logic [7:0] paddr, pwdata, prdata;
    logic       pslverr, sio_d_oe, sio_c, cam_pull;
    logic [7:0] shadow [256];                   // Expected camera registers
    wire        sio_d = ~(sio_d_oe | cam_pull); // Pulled up unless either side pulls low

    sccb_apb_top #(.CLK_DIV(CLK_DIV)) dut (
        .PCLK(PCLK), .PRESETN(PRESETN), .psel(psel), .penable(penable),
        .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
        .pslverr(pslverr), .sio_d_in(sio_d), .sio_d_oe(sio_d_oe), .sio_c(sio_c)
    );

    sccb_cam_model cam (.sio_c(sio_c), .sio_d(sio_d), .pull_low(cam_pull));

    always #10 PCLK = ~PCLK; // 20 ns period

    initial begin
        #(WD_NS);
        $display("Testbench failed");
        $fatal(1, "Simulation timed out after %0d ns", WD_NS);
    end

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
            $display("Testbench failed");
            $fatal(1, "Byte mismatch on %s", what);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("Testbench failed");
            $fatal(1, "Flag mismatch on %s", what);
        end
    endtask

    task automatic reset_dut();
        @(negedge PCLK);
        PRESETN = 1'b0;
        repeat (5) @(negedge PCLK);
        PRESETN = 1'b1;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [7:0] data);
        @(negedge PCLK);
        psel    = 1'b1; // Setup phase
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge PCLK);
        penable = 1'b1; // Zero-wait access phase
        @(negedge PCLK);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [7:0] data, output logic err);
        @(negedge PCLK);
        psel    = 1'b1;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge PCLK);
        penable = 1'b1;
        @(negedge PCLK); // Access completed on the rising edge
        data    = prdata;
        err     = pslverr;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Polls STATUS until the given bit is set
    task automatic wait_status(input int pos, output logic [7:0] st);
        logic err;
        apb_read(REG_STATUS, st, err);
        while (!st[pos])
            apb_read(REG_STATUS, st, err);
    endtask

    task automatic issue_cmd(input logic [7:0] id, input logic [7:0] sub,
                             input logic [7:0] data, input logic [7:0] ctrl);
        apb_write(REG_ID, id);
        apb_write(REG_SUB, sub);
        apb_write(REG_WDATA, data);
        apb_write(REG_CTRL, ctrl);
    endtask

    task automatic write_readback(input logic [7:0] addr, input logic [7:0] val);
        logic [7:0] rd;
        logic       err;
        apb_write(addr, val);
        apb_read(addr, rd, err);
        check_byte(rd, val, "register readback");
        check_flag(err, 1'b0, "pslverr on mapped read");
    endtask

    task automatic boot_contents();
        logic [7:0] st;
        wait_status(STAT_BOOTED, st);
        for (int i = 0; i < BOOT_LEN; i++) begin
            check_byte(cam.regs[BOOT_SUB[i]], BOOT_DATA[i], "boot register");
            shadow[BOOT_SUB[i]] = BOOT_DATA[i];
        end
    endtask

    task automatic write_random_reg(output logic [7:0] sub);
        logic [7:0] data, st;
        sub  = 8'($urandom);
        data = 8'($urandom);
        if (data == shadow[sub]) data = ~data; // Write must change the register
        issue_cmd(CAM_ID, sub, data, 8'h01);
        wait_status(STAT_DONE, st);
        check_flag(st[STAT_NACK], 1'b0, "write nack");
        shadow[sub] = data;
        check_byte(cam.regs[sub], shadow[sub], "camera register after write");
    endtask

    task automatic read_and_compare(input logic [7:0] sub);
        logic [7:0] st, rd;
        logic       err;
        issue_cmd(CAM_ID, sub, 8'h00, 8'h02);
        wait_status(STAT_DONE, st);
        check_flag(st[STAT_NACK], 1'b0, "read nack");
        apb_read(REG_RDATA, rd, err);
        check_byte(rd, shadow[sub], "RDATA");
    endtask

    task automatic nack_unknown_id();
        logic [7:0] st, sub;
        sub = 8'($urandom);
        issue_cmd(8'h60, sub, ~shadow[sub], 8'h01); // Unknown device ID
        wait_status(STAT_DONE, st);
        check_flag(st[STAT_NACK], 1'b1, "nack for unknown ID");
        for (int i = 0; i < 256; i++)
            check_byte(cam.regs[i], shadow[i], "camera register after nack");
    endtask

    task automatic reg_file_access();
        logic [7:0] rd;
        logic       err;
        write_readback(REG_ID, 8'hA5);
        write_readback(REG_SUB, 8'h3C);
        write_readback(REG_WDATA, 8'hC3);
        apb_read(8'h18, rd, err);
        check_byte(rd, 8'hFF, "unmapped read");
        check_flag(err, 1'b1, "pslverr on unmapped read");
    endtask

    // CTRL write queued behind the boot sequence
    task automatic queued_write_at_boot();
        logic [7:0] st, sub, data;
        logic       err;
        reset_dut();
        for (int i = 0; i < BOOT_LEN; i++)
            shadow[BOOT_SUB[i]] = BOOT_DATA[i]; // Boot runs again
        apb_read(REG_STATUS, st, err);
        check_byte(st, 8'h00, "STATUS after reset");
        sub  = 8'($urandom);
        data = ~shadow[sub];
        issue_cmd(CAM_ID, sub, data, 8'h01);
        apb_read(REG_STATUS, st, err);
        check_flag(st[STAT_BUSY], 1'b1, "busy behind boot");
        check_flag(st[STAT_BOOTED], 1'b0, "booted during boot");
        wait_status(STAT_DONE, st);
        check_flag(st[STAT_BOOTED], 1'b1, "booted before APB command");
        check_flag(st[STAT_NACK], 1'b0, "nack after boot");
        shadow[sub] = data;
        check_byte(cam.regs[sub], data, "camera register after queued write");
    endtask

    initial begin
        logic [7:0] wsub;
        PCLK    = 1'b0;
        PRESETN = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 8'h00;
        pwdata  = 8'h00;
        void'($urandom(32'hc9ad));
        for (int i = 0; i < 256; i++)
            shadow[i] = 8'(i) ^ 8'h5A;
        reset_dut();
        boot_contents();
        write_random_reg(wsub);
        read_and_compare(wsub);          // Value from the write
        read_and_compare(8'($urandom));  // Any other address
        nack_unknown_id();
        reg_file_access();
        queued_write_at_boot();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
sccb_pkg.sv
sccb_clk_gen.sv
sccb_master.sv
sccb_arbiter.sv
sccb_boot_seq.sv
sccb_apb_regs.sv
sccb_apb_top.sv
sccb_cam_model.sv
tb_sccb_apb.sv

//--- Makefile
TOP := tb_sccb_apb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module sccb_apb_top -f all.f
	verilator --lint-only --timing --top-module $(TOP) -f all.f

sim:
	verilator --binary --timing --top-module $(TOP) -f all.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
